// File: hdl/apb_bridge.sv
`default_nettype none

`include "mgmt_settings.svh"

module apb_bridge import mgmt_pkg::*; #(
	parameter int NUM_PORTS		= 2,
	parameter int BLOCK_BITS	= 15
) (
	input logic			sys_clk,
	input logic			reset,

	input apb_req_t		up_req,
	output apb_resp_t	up_resp,

	output apb_req_t	down_req[NUM_PORTS-1:0],
	input apb_resp_t	down_resp[NUM_PORTS-1:0]
);

	//Root split uses the half bit, everything else the small window view
	localparam bit ROOT_VIEW = (BLOCK_BITS == `MGMT_ADDR_WIDTH - 1);

	mgmt_addr_u						addr_u;
	logic[3:0]						sel_idx;
	logic[`MGMT_ADDR_WIDTH-1:0]		offset;
	logic							bad;
	logic							access;
	logic							err_q;
	apb_resp_t						sel_resp;

	//////////////////////////////////////////////////////////////////////
	// Address decode

	always_comb begin
		addr_u	= up_req.paddr;
		offset	= '0;

		if(ROOT_VIEW) begin
			sel_idx										= {3'b0, addr_u.root.half};
			offset[`MGMT_ADDR_WIDTH-2:0]				= addr_u.root.rest;
			bad											= 1'b0;
		end
		else begin
			sel_idx										= addr_u.smol.window;
			offset[`MGMT_SMOL_ADDR_WIDTH-1:0]			= addr_u.smol.offset;

			//Bits above the window index must be clear
			bad											= (addr_u.smol.unused != 2'b0);
		end

		//Index past the last port is unmapped
		if(int'(sel_idx) >= NUM_PORTS)
			bad		= 1'b1;

		access	= up_req.psel && up_req.penable;
	end

	//////////////////////////////////////////////////////////////////////
	// Request fan-out

	always_comb begin
		for(int i = 0; i < NUM_PORTS; i++) begin
			down_req[i]			= up_req;
			down_req[i].paddr	= offset;

			//Only the addressed port sees the select
			down_req[i].psel	= up_req.psel && !bad && (int'(sel_idx) == i);
			down_req[i].penable	= up_req.penable && down_req[i].psel;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response mux and local error

	//Unmapped access completes on the second access cycle
	always_ff @(posedge sys_clk) begin
		if(reset)
			err_q	<= 1'b0;
		else
			err_q	<= access && bad && !err_q;
	end

	always_comb begin
		sel_resp	= '0;
		for(int i = 0; i < NUM_PORTS; i++) begin
			if(int'(sel_idx) == i)
				sel_resp	= down_resp[i];
		end

		//Nothing goes upstream outside the access phase
		if(!access)
			up_resp	= '0;
		else if(bad)
			up_resp	= err_q ? APB_RESP_ERR : '0;
		else
			up_resp	= sel_resp;
	end

endmodule

`default_nettype wire

// File: hdl/apb_panel_status.sv
`default_nettype none

module apb_panel_status import mgmt_pkg::*; (
	input logic			sys_clk,
	input logic			reset,

	input apb_req_t		req,
	output apb_resp_t	resp,

	input logic[11:0]	trig_in_led,
	input logic[11:0]	trig_out_led,
	input logic[3:0]	relay_state,
	input logic[1:0]	rx_frame_ready,

	output logic		irq
);

	logic[11:0]		in_flipped;
	logic[11:0]		out_gated;
	logic			setup;
	logic			access;
	logic[31:0]		rdata;
	logic			bad;

	//Snapshot taken in the setup phase
	logic[31:0]		rdata_q;
	logic			err_q;

	//////////////////////////////////////////////////////////////////////
	// Status words

	always_comb begin
		//MSB to LSB, matches the expander pinout
		for(int i = 0; i < 12; i++)
			in_flipped[i]	= trig_in_led[11 - i];

		//Outputs routed through a closed relay are dark
		out_gated[7:0]		= trig_out_led[7:0];
		out_gated[11:8]		= trig_out_led[11:8] & ~relay_state;

		setup	= req.psel && !req.penable;
		access	= req.psel && req.penable;

		//Read-only block
		bad		= req.pwrite;
		case(req.paddr[7:0])
			8'h00:		rdata	= {20'h0, in_flipped};
			8'h04:		rdata	= {20'h0, out_gated};
			8'h08:		rdata	= {30'h0, rx_frame_ready};
			default: begin
				rdata	= '0;
				bad		= 1'b1;
			end
		endcase

		//Unknown offsets above the low byte
		if(req.paddr[15:8] != 8'h0)
			bad	= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// APB response

	always_ff @(posedge sys_clk) begin
		if(setup)
			rdata_q	<= rdata;
	end

	always_ff @(posedge sys_clk) begin
		if(reset)
			err_q	<= 1'b0;
		else if(setup)
			err_q	<= bad;
	end

	always_comb begin
		resp.pready		= access;
		resp.pslverr	= access && err_q;
		resp.prdata		= access ? rdata_q : '0;
	end

	//Either Ethernet port has a frame waiting
	always_comb begin
		irq	= |rx_frame_ready;
	end

endmodule

`default_nettype wire

// File: hdl/apb_reg_slice.sv
`default_nettype none

module apb_reg_slice import mgmt_pkg::*; #(
	parameter int UP_REG	= 1,
	parameter int DOWN_REG	= 0
) (
	input logic			sys_clk,
	input logic			reset,

	input apb_req_t		up_req,
	output apb_resp_t	up_resp,

	output apb_req_t	down_req,
	input apb_resp_t	down_resp
);

	//Link between the request stage and the response stage
	apb_req_t	mid_req;
	apb_resp_t	mid_resp;

	//////////////////////////////////////////////////////////////////////
	// Request path stage

	if(UP_REG != 0) begin : g_req_reg
		apb_req_t	req_q;
		logic		mid_done;

		always_comb begin
			mid_done	= req_q.psel && req_q.penable && mid_resp.pready;
			mid_req		= req_q;

			//Pass completion back only while our copy is in its access phase
			up_resp		= (req_q.psel && req_q.penable) ? mid_resp : '0;
		end

		always_ff @(posedge sys_clk) begin
			if(reset) begin
				req_q.psel		<= 1'b0;
				req_q.penable	<= 1'b0;
			end

			//Requester still shows the finished transfer this cycle, drop it
			else if(mid_done) begin
				req_q.psel		<= 1'b0;
				req_q.penable	<= 1'b0;
			end

			//Requester holds its request during waits, so this also holds
			else
				req_q			<= up_req;
		end
	end
	else begin : g_req_pass
		always_comb begin
			mid_req	= up_req;
			up_resp	= mid_resp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response path stage

	if(DOWN_REG != 0) begin : g_resp_reg
		apb_resp_t	resp_q;
		logic		down_fire;

		always_comb begin
			//Mask the select while the registered answer is shown upstream
			down_req			= mid_req;
			down_req.psel		= mid_req.psel && !resp_q.pready;
			down_req.penable	= mid_req.penable && !resp_q.pready;

			down_fire			= down_req.psel && down_req.penable && down_resp.pready;
			mid_resp			= resp_q;
		end

		always_ff @(posedge sys_clk) begin
			if(reset)
				resp_q.pready	<= 1'b0;
			else
				resp_q.pready	<= down_fire;

			//Data and error flag only
			if(down_fire) begin
				resp_q.pslverr	<= down_resp.pslverr;
				resp_q.prdata	<= down_resp.prdata;
			end
		end
	end
	else begin : g_resp_pass
		always_comb begin
			down_req	= mid_req;
			mid_resp	= down_resp;
		end
	end

endmodule

`default_nettype wire

// File: hdl/apb_sysinfo.sv
`default_nettype none

`include "mgmt_settings.svh"

module apb_sysinfo import mgmt_pkg::*; (
	input logic			sys_clk,
	input logic			reset,

	input apb_req_t		req,
	output apb_resp_t	resp,

	input logic[15:0]	fan0_speed,
	input logic[15:0]	fan1_speed
);

	//Register map
	localparam logic[`MGMT_SMOL_ADDR_WIDTH-1:0] REG_ID		= 'h0;
	localparam logic[`MGMT_SMOL_ADDR_WIDTH-1:0] REG_SCRATCH	= 'h4;
	localparam logic[`MGMT_SMOL_ADDR_WIDTH-1:0] REG_FAN		= 'h8;

	logic								access;
	logic[`MGMT_SMOL_ADDR_WIDTH-1:0]	offset;
	logic[`MGMT_DATA_WIDTH-1:0]			scratch;

	//////////////////////////////////////////////////////////////////////
	// Read mux and completion

	always_comb begin
		access	= req.psel && req.penable;
		offset	= req.paddr[`MGMT_SMOL_ADDR_WIDTH-1:0];
		resp	= '0;

		//Always done on the first access cycle
		if(access) begin
			resp.pready	= 1'b1;
			case(offset)
				REG_ID: begin
					resp.prdata		= `MGMT_SYSINFO_ID;
					resp.pslverr	= req.pwrite;
				end

				REG_SCRATCH:
					resp.prdata		= scratch;

				//fan1 in upper half
				REG_FAN: begin
					resp.prdata		= {fan1_speed, fan0_speed};
					resp.pslverr	= req.pwrite;
				end

				default:
					resp.pslverr	= 1'b1;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Scratch register

	always_ff @(posedge sys_clk) begin
		if(reset)
			scratch	<= '0;
		else if(access && req.pwrite && (offset == REG_SCRATCH))
			scratch	<= req.pwdata;
	end

endmodule

`default_nettype wire

// File: hdl/fan_tachometer.sv
`default_nettype none

`include "mgmt_settings.svh"

module fan_tachometer (
	input logic			sys_clk,
	input logic			reset,
	input logic			tach,

	output logic[15:0]	speed
);

	localparam int WIN_BITS = $clog2(`MGMT_TACH_WINDOW);

	//Two sync stages plus one for edge detect
	logic[2:0]				tach_sync;
	logic					rise;

	logic[WIN_BITS-1:0]		win_count;
	logic					win_end;
	logic[15:0]				pulse_count;

	//////////////////////////////////////////////////////////////////////
	// Input synchronizer

	always_ff @(posedge sys_clk) begin
		tach_sync	<= {tach_sync[1:0], tach};
	end

	always_comb begin
		rise	= tach_sync[1] && !tach_sync[2];
		win_end	= (win_count == WIN_BITS'(`MGMT_TACH_WINDOW - 1));
	end

	//////////////////////////////////////////////////////////////////////
	// Gate window and pulse counter

	always_ff @(posedge sys_clk) begin
		if(reset) begin
			win_count	<= '0;
			pulse_count	<= '0;
			speed		<= '0;
		end

		//Publish and restart, an edge in the last cycle goes to the next window
		else if(win_end) begin
			win_count	<= '0;
			pulse_count	<= {15'b0, rise};
			speed		<= 16'(pulse_count * `MGMT_TACH_SCALE);
		end

		else begin
			win_count	<= win_count + 1'b1;
			pulse_count	<= pulse_count + {15'b0, rise};
		end
	end

endmodule

`default_nettype wire

// File: hdl/mgmt_pkg.sv
`default_nettype none

`include "mgmt_settings.svh"

package mgmt_pkg;

	//////////////////////////////////////////////////////////////////////
	// APB link

	//Requester side of a link
	typedef struct packed {
		logic								psel;
		logic								penable;
		logic								pwrite;
		logic[`MGMT_ADDR_WIDTH-1:0]			paddr;
		logic[`MGMT_DATA_WIDTH-1:0]			pwdata;
	} apb_req_t;

	//Completer side of a link
	typedef struct packed {
		logic								pready;
		logic								pslverr;
		logic[`MGMT_DATA_WIDTH-1:0]			prdata;
	} apb_resp_t;

	//Error answer, also used as tie-off for an empty window
	localparam apb_resp_t APB_RESP_ERR = '{pready: 1'b1, pslverr: 1'b1, prdata: '0};

	//////////////////////////////////////////////////////////////////////
	// Address decode

	//Same host address word, seen by the root or by the small bridge
	typedef union packed {
		struct packed {
			logic								half;
			logic[`MGMT_ADDR_WIDTH-2:0]			rest;
		} root;
		struct packed {
			logic[1:0]							unused;
			logic[3:0]							window;
			logic[`MGMT_SMOL_ADDR_WIDTH-1:0]	offset;
		} smol;
	} mgmt_addr_u;

endpackage

`default_nettype wire

// File: hdl/mgmt_settings.svh
`ifndef MGMT_SETTINGS_SVH
`define MGMT_SETTINGS_SVH

//Bus widths
`define MGMT_DATA_WIDTH			32
`define MGMT_ADDR_WIDTH			16

//Offset widths inside one decoder window
`define MGMT_SMOL_ADDR_WIDTH	10
`define MGMT_BIG_ADDR_WIDTH		12

//Endpoint count on the small window bridge
`define MGMT_NUM_SMOL			4

//Tachometer gate time in sys_clk cycles (short for simulation)
`define MGMT_TACH_WINDOW		1000
`define MGMT_TACH_SCALE			60

//Value of the read-only ID register
`define MGMT_SYSINFO_ID			32'h7c0b_a5e1

`endif

// File: hdl/mgmt_subsystem.sv
`default_nettype none

`include "mgmt_settings.svh"

module mgmt_subsystem import mgmt_pkg::*; (
	input logic			sys_clk,
	input logic			reset,

	//Host port
	input apb_req_t		host_req,
	output apb_resp_t	host_resp,

	//External completers
	output apb_req_t	relay_req,
	input apb_resp_t	relay_resp,
	output apb_req_t	big_req,
	input apb_resp_t	big_resp,

	//Fan tachometers
	input logic[1:0]	fan_tach,

	//Front panel and Ethernet status
	input logic[11:0]	trig_in_led,
	input logic[11:0]	trig_out_led,
	input logic[3:0]	relay_state,
	input logic[1:0]	rx_frame_ready,
	output logic		irq
);

	//////////////////////////////////////////////////////////////////////
	// Root bridge, 0x8000 per half

	apb_req_t	root_req[1:0];
	apb_resp_t	root_resp[1:0];

	apb_bridge #(.NUM_PORTS(2), .BLOCK_BITS(`MGMT_ADDR_WIDTH - 1)) u_root (
		.sys_clk(sys_clk), .reset(reset),
		.up_req(host_req), .up_resp(host_resp),
		.down_req(root_req), .down_resp(root_resp));

	//////////////////////////////////////////////////////////////////////
	// Small window bridge, 0x400 per endpoint

	apb_req_t	smol_up_req;
	apb_resp_t	smol_up_resp;
	apb_req_t	smol_req[`MGMT_NUM_SMOL-1:0];
	apb_resp_t	smol_resp[`MGMT_NUM_SMOL-1:0];

	apb_reg_slice #(.UP_REG(1), .DOWN_REG(1)) u_slice_smol (
		.sys_clk(sys_clk), .reset(reset),
		.up_req(root_req[0]), .up_resp(root_resp[0]),
		.down_req(smol_up_req), .down_resp(smol_up_resp));

	apb_bridge #(.NUM_PORTS(`MGMT_NUM_SMOL), .BLOCK_BITS(`MGMT_SMOL_ADDR_WIDTH)) u_smol (
		.sys_clk(sys_clk), .reset(reset),
		.up_req(smol_up_req), .up_resp(smol_up_resp),
		.down_req(smol_req), .down_resp(smol_resp));

	//Window 3 is empty
	assign smol_resp[3] = APB_RESP_ERR;

	//////////////////////////////////////////////////////////////////////
	// System information (0x0000)

	logic[15:0]	fan0_speed;
	logic[15:0]	fan1_speed;

	fan_tachometer u_tach0 (.sys_clk(sys_clk), .reset(reset), .tach(fan_tach[0]),
		.speed(fan0_speed));
	fan_tachometer u_tach1 (.sys_clk(sys_clk), .reset(reset), .tach(fan_tach[1]),
		.speed(fan1_speed));

	apb_sysinfo u_sysinfo (
		.sys_clk(sys_clk), .reset(reset),
		.req(smol_req[0]), .resp(smol_resp[0]),
		.fan0_speed(fan0_speed), .fan1_speed(fan1_speed));

	//////////////////////////////////////////////////////////////////////
	// Front panel status and irq (0x0400)

	apb_panel_status u_panel (
		.sys_clk(sys_clk), .reset(reset),
		.req(smol_req[1]), .resp(smol_resp[1]),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led),
		.relay_state(relay_state), .rx_frame_ready(rx_frame_ready),
		.irq(irq));

	//////////////////////////////////////////////////////////////////////
	// External ports

	//Relay controller (0x0800)
	apb_reg_slice #(.UP_REG(1), .DOWN_REG(0)) u_slice_relay (
		.sys_clk(sys_clk), .reset(reset),
		.up_req(smol_req[2]), .up_resp(smol_resp[2]),
		.down_req(relay_req), .down_resp(relay_resp));

	//Big window (0x8000)
	apb_req_t	big_slice_req;

	apb_reg_slice #(.UP_REG(1), .DOWN_REG(0)) u_slice_big (
		.sys_clk(sys_clk), .reset(reset),
		.up_req(root_req[1]), .up_resp(root_resp[1]),
		.down_req(big_slice_req), .down_resp(big_resp));

	//Single 4 KB block, upper offset bits alias
	always_comb begin
		big_req			= big_slice_req;
		big_req.paddr	= '0;
		big_req.paddr[`MGMT_BIG_ADDR_WIDTH-1:0] = big_slice_req.paddr[`MGMT_BIG_ADDR_WIDTH-1:0];
	end

endmodule

`default_nettype wire

// File: mgmt_subsystem.f
+incdir+hdl
hdl/mgmt_pkg.sv
hdl/apb_bridge.sv
hdl/apb_reg_slice.sv
hdl/fan_tachometer.sv
hdl/apb_sysinfo.sv
hdl/apb_panel_status.sv
hdl/mgmt_subsystem.sv
verification/mgmt_subsystem_assert.sv
verification/mgmt_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

# Build and run the management subsystem testbench with Verilator
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f mgmt_subsystem.f \
	--top-module mgmt_subsystem_tb \
	-Mdir obj_dir

# The simulator exit code is not trusted, the log decides
./obj_dir/Vmgmt_subsystem_tb 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: verification/mgmt_subsystem_assert.sv
`default_nettype none

module mgmt_subsystem_assert import mgmt_pkg::*; (
	input logic			sys_clk,
	input logic			reset,
	input apb_req_t		host_req,
	input apb_resp_t	host_resp,
	input apb_req_t		relay_req,
	input apb_resp_t	relay_resp,
	input apb_req_t		big_req,
	input apb_resp_t	big_resp
);

	//Link 0 is the host port, 1 relay, 2 big window
	apb_req_t	req[3];
	apb_resp_t	resp[3];

	always_comb begin
		req[0]	= host_req;
		resp[0]	= host_resp;
		req[1]	= relay_req;
		resp[1]	= relay_resp;
		req[2]	= big_req;
		resp[2]	= big_resp;
	end

	//////////////////////////////////////////////////////////////////////
	// Protocol rules per link

	for(genvar i = 0; i < 3; i++) begin : g_link
		//Select stays up until the completer answers
		assert property (@(posedge sys_clk) disable iff (reset)
			req[i].psel && !(req[i].penable && resp[i].pready) |=> req[i].psel)
			else $error("psel dropped before pready on link %0d", i);

		//Setup phase lasts exactly one cycle
		assert property (@(posedge sys_clk) disable iff (reset)
			req[i].psel && !req[i].penable |=> req[i].psel && req[i].penable)
			else $error("penable did not follow psel on link %0d", i);

		//Address, direction and data frozen until completion
		assert property (@(posedge sys_clk) disable iff (reset)
			req[i].psel && !(req[i].penable && resp[i].pready) |=>
			$stable(req[i].paddr) && $stable(req[i].pwrite) && $stable(req[i].pwdata))
			else $error("request changed during wait on link %0d", i);
	end

	//Quiet links right after reset
	assert property (@(posedge sys_clk)
		reset |=> !host_resp.pready && !relay_req.psel && !big_req.psel)
		else $error("link active right after reset");

endmodule

bind mgmt_subsystem mgmt_subsystem_assert u_assert (
	.sys_clk(sys_clk), .reset(reset),
	.host_req(host_req), .host_resp(host_resp),
	.relay_req(relay_req), .relay_resp(relay_resp),
	.big_req(big_req), .big_resp(big_resp));

`default_nettype wire

// File: verification/mgmt_subsystem_tb.sv
`default_nettype none

`include "mgmt_settings.svh"

module mgmt_subsystem_tb import mgmt_pkg::*; ();

	localparam int PERIOD		= 4;
	localparam int RESET_CYCLES	= 5;
	localparam int LED_ROUNDS	= 8;
	localparam int RELAY_ROUNDS	= 4;
	localparam int BIG_ROUNDS	= 16;

	//Tach periods in sys_clk cycles
	localparam int TACH_P0		= 20;
	localparam int TACH_P1		= 37;

	//Completer models answer offset XOR key
	localparam logic[31:0] RELAY_KEY	= 32'h5e1a_0000;
	localparam logic[31:0] BIG_KEY		= 32'h0b19_0000;

	//Longest transfer is the big window with 3 waits plus slack
	localparam int XFER_CYCLES		= 16;
	localparam int XFER_LIMIT		= 64;
	localparam int NUM_XFERS		= 3 + 2*LED_ROUNDS + 4 + 2*RELAY_ROUNDS + BIG_ROUNDS + 1 + 4 + 1;
	localparam int RUN_CYCLES		= RESET_CYCLES + NUM_XFERS*XFER_CYCLES
										+ 3*`MGMT_TACH_WINDOW + 64;
	localparam int WATCHDOG_TIME	= 2 * RUN_CYCLES * PERIOD;

	logic			sys_clk;
	logic			reset;
	apb_req_t		host_req;
	apb_resp_t		host_resp;
	apb_req_t		relay_req;
	apb_resp_t		relay_resp;
	apb_req_t		big_req;
	apb_resp_t		big_resp;
	logic[1:0]		fan_tach;
	logic[11:0]		trig_in_led;
	logic[11:0]		trig_out_led;
	logic[3:0]		relay_state;
	logic[1:0]		rx_frame_ready;
	logic			irq;

	integer			seed		= 32'h585a_06fd;
	logic			tach_on		= 1'b0;

	//Last access seen by each completer model
	logic[15:0]		relay_addr_seen;
	logic			relay_write_seen;
	logic[31:0]		relay_wdata_seen;
	logic[15:0]		big_addr_seen;
	logic			big_write_seen;
	logic[31:0]		big_wdata_seen;
	int				big_wait;

	mgmt_subsystem u_dut (
		.sys_clk(sys_clk), .reset(reset),
		.host_req(host_req), .host_resp(host_resp),
		.relay_req(relay_req), .relay_resp(relay_resp),
		.big_req(big_req), .big_resp(big_resp),
		.fan_tach(fan_tach),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led),
		.relay_state(relay_state), .rx_frame_ready(rx_frame_ready),
		.irq(irq));

	initial begin
		sys_clk	= 1'b0;
		forever #(PERIOD/2) sys_clk = ~sys_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Completer models and tach source

	//Relay controller answers on the first access cycle
	initial begin
		relay_resp	= '0;
		forever begin
			@(posedge sys_clk);
			#1;
			relay_resp	= '0;
			if(relay_req.psel && relay_req.penable) begin
				relay_resp.pready	= 1'b1;
				relay_resp.prdata	= {16'h0, relay_req.paddr} ^ RELAY_KEY;
				relay_addr_seen		= relay_req.paddr;
				relay_write_seen	= relay_req.pwrite;
				relay_wdata_seen	= relay_req.pwdata;
			end
		end
	end

	//Big window adds 0 to 3 random wait cycles per transfer
	initial begin
		big_resp	= '0;
		big_wait	= -1;
		forever begin
			@(posedge sys_clk);
			#1;
			big_resp	= '0;
			if(big_req.psel && big_req.penable) begin
				if(big_wait < 0)
					big_wait	= $random(seed) & 32'h3;
				if(big_wait == 0) begin
					big_resp.pready	= 1'b1;
					big_resp.prdata	= {16'h0, big_req.paddr} ^ BIG_KEY;
					big_addr_seen	= big_req.paddr;
					big_write_seen	= big_req.pwrite;
					big_wdata_seen	= big_req.pwdata;
					big_wait		= -1;
				end
				else
					big_wait	= big_wait - 1;
			end
		end
	end

	//One rising tach edge per period at half duty
	initial begin
		int phase0;
		int phase1;
		fan_tach	= '0;
		phase0		= 0;
		phase1		= 0;
		forever begin
			@(posedge sys_clk);
			#1;
			if(tach_on) begin
				phase0		= (phase0 + 1) % TACH_P0;
				phase1		= (phase1 + 1) % TACH_P1;
				fan_tach[0]	= (phase0 < TACH_P0/2);
				fan_tach[1]	= (phase1 < TACH_P1/2);
			end
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		fail_run($sformatf("watchdog expired at time %0t, the tests did not finish", $time));
	end

	//////////////////////////////////////////////////////////////////////
	// Host driver and checks

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string what, input logic[31:0] got, input logic[31:0] exp);
		assert(got === exp)
			else fail_run($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	//Starts and ends one time unit after a rising edge
	task automatic host_transfer(input logic write, input logic[15:0] addr,
		input logic[31:0] wdata, output logic[31:0] rdata, output logic err);
		int waited;
		host_req.psel		= 1'b1;
		host_req.penable	= 1'b0;
		host_req.pwrite		= write;
		host_req.paddr		= addr;
		host_req.pwdata		= wdata;
		@(posedge sys_clk);
		#1;
		host_req.penable	= 1'b1;
		waited				= 0;
		@(negedge sys_clk);
		while(!host_resp.pready) begin
			waited++;
			if(waited > XFER_LIMIT)
				fail_run($sformatf("no pready on the host port for address %h", addr));
			@(negedge sys_clk);
		end
		rdata	= host_resp.prdata;
		err		= host_resp.pslverr;
		@(posedge sys_clk);
		#1;
		host_req.psel		= 1'b0;
		host_req.penable	= 1'b0;
	endtask

	task automatic expect_read(input string what, input logic[15:0] addr,
		input logic[31:0] exp);
		logic[31:0]	rdata;
		logic		err;
		host_transfer(1'b0, addr, '0, rdata, err);
		check_word({what, " error flag"}, {31'b0, err}, 32'h0);
		check_word(what, rdata, exp);
	endtask

	task automatic write_word(input logic[15:0] addr, input logic[31:0] wdata);
		logic[31:0]	rdata;
		logic		err;
		host_transfer(1'b1, addr, wdata, rdata, err);
		check_word($sformatf("write error flag at %h", addr), {31'b0, err}, 32'h0);
	endtask

	task automatic expect_error(input string what, input logic write, input logic[15:0] addr);
		logic[31:0]	rdata;
		logic		err;
		host_transfer(write, addr, 32'hdead_beef, rdata, err);
		check_word({what, " error flag"}, {31'b0, err}, 32'h1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test steps

	task automatic sysinfo_regs();
		logic[31:0]	val;
		val	= $random(seed);
		expect_read("sysinfo ID", 16'h0000, `MGMT_SYSINFO_ID);
		write_word(16'h0004, val);
		expect_read("scratch readback", 16'h0004, val);
	endtask

	task automatic led_words();
		logic[11:0]	flipped;
		logic[11:0]	gated;
		for(int i = 0; i < LED_ROUNDS; i++) begin
			trig_in_led		= 12'($random(seed));
			trig_out_led	= 12'($random(seed));
			relay_state		= 4'($random(seed));
			//Bit 0 of the register is input 11
			flipped			= {<<{trig_in_led}};
			gated			= trig_out_led & ~{relay_state, 8'h00};
			expect_read("input LED word", 16'h0400, {20'h0, flipped});
			expect_read("output LED word", 16'h0404, {20'h0, gated});
		end
	endtask

	task automatic irq_status();
		for(int v = 0; v < 4; v++) begin
			rx_frame_ready	= 2'(v);
			@(negedge sys_clk);
			check_word("irq pin", {31'b0, irq}, {31'b0, (v != 0)});
			@(posedge sys_clk);
			#1;
			expect_read("frame ready status", 16'h0408, 32'(v));
		end
		rx_frame_ready	= '0;
	endtask

	task automatic external_windows();
		logic[9:0]	off;
		logic[15:0]	addr;
		logic[31:0]	val;
		for(int i = 0; i < RELAY_ROUNDS; i++) begin
			off	= 10'($random(seed)) & ~10'h3;
			val	= $random(seed);
			write_word(16'h0800 | {6'h0, off}, val);
			check_word("relay write offset", {16'h0, relay_addr_seen}, {22'h0, off});
			check_word("relay write flag", {31'b0, relay_write_seen}, 32'h1);
			check_word("relay write data", relay_wdata_seen, val);
			expect_read("relay read data", 16'h0800 | {6'h0, off}, {22'h0, off} ^ RELAY_KEY);
			check_word("relay read flag", {31'b0, relay_write_seen}, 32'h0);
		end

		//Addresses across the upper half alias onto one 4 KB block
		for(int i = 0; i < BIG_ROUNDS; i++) begin
			addr	= 16'h8000 | (16'($random(seed)) & 16'h7ffc);
			expect_read("big window data", addr, {20'h0, addr[11:0]} ^ BIG_KEY);
			check_word("big window offset", {16'h0, big_addr_seen}, {20'h0, addr[11:0]});
			check_word("big read flag", {31'b0, big_write_seen}, 32'h0);
		end
		write_word(16'ha010, 32'h1234_5678);
		check_word("big write offset", {16'h0, big_addr_seen}, 32'h0000_0010);
		check_word("big write flag", {31'b0, big_write_seen}, 32'h1);
		check_word("big write data", big_wdata_seen, 32'h1234_5678);
	endtask

	task automatic error_responses();
		expect_error("empty window 3", 1'b0, 16'h0c00);
		expect_error("unknown sysinfo offset", 1'b0, 16'h000c);
		expect_error("write to sysinfo ID", 1'b1, 16'h0000);
		expect_error("window index above 3", 1'b0, 16'h1000);
	endtask

	task automatic fan_speeds();
		int			exp0;
		int			exp1;
		logic[31:0]	rdata;
		logic		err;
		exp0	= `MGMT_TACH_SCALE * `MGMT_TACH_WINDOW / TACH_P0;
		exp1	= `MGMT_TACH_SCALE * `MGMT_TACH_WINDOW / TACH_P1;
		tach_on	= 1'b1;
		//Last published window lies fully inside the pulse train
		repeat(3 * `MGMT_TACH_WINDOW) @(posedge sys_clk);
		#1;
		host_transfer(1'b0, 16'h0008, '0, rdata, err);
		check_word("fan speed error flag", {31'b0, err}, 32'h0);
		assert((int'(rdata[15:0]) >= exp0 - `MGMT_TACH_SCALE)
			&& (int'(rdata[15:0]) <= exp0 + `MGMT_TACH_SCALE))
			else fail_run($sformatf("MISMATCH at time %0t: fan 0 speed is %0d, expected %0d",
				$time, rdata[15:0], exp0));
		assert((int'(rdata[31:16]) >= exp1 - `MGMT_TACH_SCALE)
			&& (int'(rdata[31:16]) <= exp1 + `MGMT_TACH_SCALE))
			else fail_run($sformatf("MISMATCH at time %0t: fan 1 speed is %0d, expected %0d",
				$time, rdata[31:16], exp1));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		reset			= 1'b1;
		host_req		= '0;
		trig_in_led		= '0;
		trig_out_led	= '0;
		relay_state		= '0;
		rx_frame_ready	= '0;
		repeat(RESET_CYCLES) @(posedge sys_clk);
		#1;
		reset	= 1'b0;
		@(posedge sys_clk);
		#1;

		sysinfo_regs();
		led_words();
		irq_status();
		external_windows();
		error_responses();
		fan_speeds();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
